//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Everything a master drives on the five channels.
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    // Everything a slave drives back.
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- fabric_pkg.sv
`default_nettype none

package fabric_pkg;

    import axil_pkg::*;

    localparam int NUM_SLV = 3;

    // Slave index: lpmem 0, syscfg 1, to_hsdom 2.
    typedef logic [1:0] slv_idx_t;

    // Region bounds are inclusive and the entry position is the slave index.
    localparam addr_t SLV_START [NUM_SLV] = '{
        32'h0000_0000,
        32'h0000_8000,
        32'h0008_0000
    };

    localparam addr_t SLV_END [NUM_SLV] = '{
        32'h0000_7FFF,
        32'h0000_83FF,
        32'hFFFF_FFFF
    };

    // The offset is the address relative to the start of the matched region.
    typedef struct packed {
        slv_idx_t idx;
        addr_t    offset;
        logic     err;
    } decode_t;

endpackage

`default_nettype wire

//--- addr_decoder.sv
`default_nettype none

module addr_decoder
    import axil_pkg::*;
    import fabric_pkg::*;
(
    input  addr_t   addr,
    output decode_t dec
);

    // The regions do not overlap, so at most one of them can match.
    always_comb begin
        dec.idx    = '0;
        dec.offset = '0;
        dec.err    = 1'b1;
        for (int i = 0; i < NUM_SLV; i++) begin
            if (addr >= SLV_START[i] && addr <= SLV_END[i]) begin
                dec.idx    = slv_idx_t'(i);
                dec.offset = addr - SLV_START[i];
                dec.err    = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
    parameter int NUM_MST = 2
) (
    input  logic               seq,
    input  logic               rst_n,
    input  logic [NUM_MST-1:0] req,
    input  logic               advance,
    output logic [NUM_MST-1:0] gnt
);

    localparam int IDX_W = $clog2(NUM_MST);

    typedef logic [IDX_W-1:0] mst_idx_t;

    mst_idx_t ptr;
    mst_idx_t gnt_idx;

    // Scan all masters once, starting at the pointer and wrapping around.
    always_comb begin
        int   cand;
        logic found;
        gnt     = '0;
        gnt_idx = ptr;
        found   = 1'b0;
        for (int k = 0; k < NUM_MST; k++) begin
            cand = (int'(ptr) + k) % NUM_MST;
            if (!found && req[cand]) begin
                gnt[cand] = 1'b1;
                gnt_idx   = mst_idx_t'(cand);
                found     = 1'b1;
            end
        end
    end

    // The winner drops to lowest priority for the next round.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance) begin
            if (int'(gnt_idx) == NUM_MST - 1) begin
                ptr <= '0;
            end else begin
                ptr <= gnt_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- axil_write_switch.sv
`default_nettype none

module axil_write_switch
    import axil_pkg::*;
    import fabric_pkg::*;
#(
    parameter int NUM_MST = 2
) (
    input  logic      seq,
    input  logic      rst_n,
    input  axil_req_t mst_req [NUM_MST],
    output axil_rsp_t mst_rsp [NUM_MST],
    output axil_req_t slv_req [NUM_SLV],
    input  axil_rsp_t slv_rsp [NUM_SLV],
    input  logic      grant_en,
    output logic      busy
);

    localparam int IDX_W = $clog2(NUM_MST);

    typedef logic [IDX_W-1:0] mst_idx_t;
    typedef enum logic [1:0] {IDLE, SLAVE, RESP} state_t;

    state_t             state;
    logic [NUM_MST-1:0] req;
    logic [NUM_MST-1:0] gnt;
    logic               accept;
    mst_idx_t           gnt_idx;
    addr_t              gnt_addr;
    decode_t            gnt_dec;
    mst_idx_t           win_q;
    decode_t            dec_q;
    data_t              data_q;
    strb_t              strb_q;
    resp_t              b_resp_q;
    logic               aw_done;
    logic               w_done;
    axil_rsp_t          s_rsp;

    // A master competes only with AW and W both valid.
    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            req[m] = grant_en && (state == IDLE) && mst_req[m].aw_valid && mst_req[m].w_valid;
        end
    end

    assign accept = |gnt;

    rr_arbiter #(
        .NUM_MST (NUM_MST)
    ) u_arb (
        .seq     (seq),
        .rst_n   (rst_n),
        .req     (req),
        .advance (accept),
        .gnt     (gnt)
    );

    always_comb begin
        gnt_idx  = '0;
        gnt_addr = '0;
        for (int m = 0; m < NUM_MST; m++) begin
            if (gnt[m]) begin
                gnt_idx  = mst_idx_t'(m);
                gnt_addr = mst_req[m].aw_addr;
            end
        end
    end

    addr_decoder u_dec (
        .addr (gnt_addr),
        .dec  (gnt_dec)
    );

    assign s_rsp = slv_rsp[dec_q.idx];

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            win_q   <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        win_q   <= gnt_idx;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        // A decode miss never reaches a slave.
                        state   <= gnt_dec.err ? RESP : SLAVE;
                    end
                end
                SLAVE: begin
                    if (s_rsp.aw_ready) begin
                        aw_done <= 1'b1;
                    end
                    if (s_rsp.w_ready) begin
                        w_done <= 1'b1;
                    end
                    if (s_rsp.b_valid) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (mst_req[win_q].b_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (accept) begin
            dec_q  <= gnt_dec;
            data_q <= mst_req[gnt_idx].w_data;
            strb_q <= mst_req[gnt_idx].w_strb;
        end
        if (accept && gnt_dec.err) begin
            b_resp_q <= RESP_DECERR;
        end else if (state == SLAVE && s_rsp.b_valid) begin
            b_resp_q <= s_rsp.b_resp;
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            mst_rsp[m] = '0;
        end
        for (int s = 0; s < NUM_SLV; s++) begin
            slv_req[s] = '0;
        end
        if (accept) begin
            mst_rsp[gnt_idx].aw_ready = 1'b1;
            mst_rsp[gnt_idx].w_ready  = 1'b1;
        end
        if (state == SLAVE) begin
            slv_req[dec_q.idx].aw_valid = !aw_done;
            slv_req[dec_q.idx].aw_addr  = dec_q.offset;
            slv_req[dec_q.idx].w_valid  = !w_done;
            slv_req[dec_q.idx].w_data   = data_q;
            slv_req[dec_q.idx].w_strb   = strb_q;
            slv_req[dec_q.idx].b_ready  = 1'b1;
        end
        if (state == RESP) begin
            mst_rsp[win_q].b_valid = 1'b1;
            mst_rsp[win_q].b_resp  = b_resp_q;
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- axil_read_switch.sv
`default_nettype none

module axil_read_switch
    import axil_pkg::*;
    import fabric_pkg::*;
#(
    parameter int NUM_MST = 2
) (
    input  logic      seq,
    input  logic      rst_n,
    input  axil_req_t mst_req [NUM_MST],
    output axil_rsp_t mst_rsp [NUM_MST],
    output axil_req_t slv_req [NUM_SLV],
    input  axil_rsp_t slv_rsp [NUM_SLV],
    input  logic      grant_en,
    output logic      busy
);

    localparam int IDX_W = $clog2(NUM_MST);

    typedef logic [IDX_W-1:0] mst_idx_t;
    typedef enum logic [1:0] {IDLE, SLAVE, RESP} state_t;

    state_t             state;
    logic [NUM_MST-1:0] req;
    logic [NUM_MST-1:0] gnt;
    logic               accept;
    mst_idx_t           gnt_idx;
    addr_t              gnt_addr;
    decode_t            gnt_dec;
    mst_idx_t           win_q;
    decode_t            dec_q;
    data_t              r_data_q;
    resp_t              r_resp_q;
    logic               ar_done;
    axil_rsp_t          s_rsp;

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            req[m] = grant_en && (state == IDLE) && mst_req[m].ar_valid;
        end
    end

    assign accept = |gnt;

    rr_arbiter #(
        .NUM_MST (NUM_MST)
    ) u_arb (
        .seq     (seq),
        .rst_n   (rst_n),
        .req     (req),
        .advance (accept),
        .gnt     (gnt)
    );

    always_comb begin
        gnt_idx  = '0;
        gnt_addr = '0;
        for (int m = 0; m < NUM_MST; m++) begin
            if (gnt[m]) begin
                gnt_idx  = mst_idx_t'(m);
                gnt_addr = mst_req[m].ar_addr;
            end
        end
    end

    addr_decoder u_dec (
        .addr (gnt_addr),
        .dec  (gnt_dec)
    );

    assign s_rsp = slv_rsp[dec_q.idx];

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            win_q   <= '0;
            ar_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        win_q   <= gnt_idx;
                        ar_done <= 1'b0;
                        state   <= gnt_dec.err ? RESP : SLAVE;
                    end
                end
                SLAVE: begin
                    if (s_rsp.ar_ready) begin
                        ar_done <= 1'b1;
                    end
                    if (s_rsp.r_valid) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (mst_req[win_q].r_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read data is held here until the master takes it.
    always_ff @(posedge seq) begin
        if (accept) begin
            dec_q <= gnt_dec;
        end
        if (accept && gnt_dec.err) begin
            r_data_q <= '0;
            r_resp_q <= RESP_DECERR;
        end else if (state == SLAVE && s_rsp.r_valid) begin
            r_data_q <= s_rsp.r_data;
            r_resp_q <= s_rsp.r_resp;
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            mst_rsp[m] = '0;
        end
        for (int s = 0; s < NUM_SLV; s++) begin
            slv_req[s] = '0;
        end
        if (accept) begin
            mst_rsp[gnt_idx].ar_ready = 1'b1;
        end
        if (state == SLAVE) begin
            slv_req[dec_q.idx].ar_valid = !ar_done;
            slv_req[dec_q.idx].ar_addr  = dec_q.offset;
            slv_req[dec_q.idx].r_ready  = 1'b1;
        end
        if (state == RESP) begin
            mst_rsp[win_q].r_valid = 1'b1;
            mst_rsp[win_q].r_data  = r_data_q;
            mst_rsp[win_q].r_resp  = r_resp_q;
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- fabric_pause_ctrl.sv
`default_nettype none

module fabric_pause_ctrl (
    input  logic seq,
    input  logic rst_n,
    input  logic pause,
    input  logic wr_busy,
    input  logic rd_busy,
    output logic grant_en,
    output logic paused
);

    logic idle;

    assign idle = !wr_busy && !rd_busy;

    // New grants stop at once; transactions already granted run to completion.
    assign grant_en = !pause;

    // With grants blocked neither path can turn busy again, so paused stays
    // high until pause is released.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            paused <= 1'b0;
        end else if (!pause) begin
            paused <= 1'b0;
        end else if (idle) begin
            paused <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- lsdom_fabric.sv
`default_nettype none

module lsdom_fabric
    import axil_pkg::*;
    import fabric_pkg::*;
#(
    parameter int NUM_MST = 2
) (
    input  logic      seq,
    input  logic      rst_n,
    input  axil_req_t mst_req [NUM_MST],
    output axil_rsp_t mst_rsp [NUM_MST],
    output axil_req_t slv_req [NUM_SLV],
    input  axil_rsp_t slv_rsp [NUM_SLV],
    input  logic      pause,
    output logic      paused
);

    axil_rsp_t wr_mst_rsp [NUM_MST];
    axil_rsp_t rd_mst_rsp [NUM_MST];
    axil_req_t wr_slv_req [NUM_SLV];
    axil_req_t rd_slv_req [NUM_SLV];
    logic      wr_busy;
    logic      rd_busy;
    logic      grant_en;

    axil_write_switch #(
        .NUM_MST (NUM_MST)
    ) u_wr_switch (
        .seq      (seq),
        .rst_n    (rst_n),
        .mst_req  (mst_req),
        .mst_rsp  (wr_mst_rsp),
        .slv_req  (wr_slv_req),
        .slv_rsp  (slv_rsp),
        .grant_en (grant_en),
        .busy     (wr_busy)
    );

    axil_read_switch #(
        .NUM_MST (NUM_MST)
    ) u_rd_switch (
        .seq      (seq),
        .rst_n    (rst_n),
        .mst_req  (mst_req),
        .mst_rsp  (rd_mst_rsp),
        .slv_req  (rd_slv_req),
        .slv_rsp  (slv_rsp),
        .grant_en (grant_en),
        .busy     (rd_busy)
    );

    fabric_pause_ctrl u_pause_ctrl (
        .seq      (seq),
        .rst_n    (rst_n),
        .pause    (pause),
        .wr_busy  (wr_busy),
        .rd_busy  (rd_busy),
        .grant_en (grant_en),
        .paused   (paused)
    );

    // Each switch keeps the other path's fields at zero, so OR merges them.
    for (genvar m = 0; m < NUM_MST; m++) begin : g_mst
        assign mst_rsp[m] = wr_mst_rsp[m] | rd_mst_rsp[m];
    end

    for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
        assign slv_req[s] = wr_slv_req[s] | rd_slv_req[s];
    end

endmodule

`default_nettype wire

//--- lsdom_fabric_assert.sv
`default_nettype none

module lsdom_fabric_assert
    import axil_pkg::*;
    import fabric_pkg::*;
#(
    parameter int NUM_MST = 2
) (
    input logic      seq,
    input logic      rst_n,
    input axil_req_t mst_req [NUM_MST],
    input axil_rsp_t mst_rsp [NUM_MST],
    input axil_req_t slv_req [NUM_SLV],
    input axil_rsp_t slv_rsp [NUM_SLV],
    input logic      paused,
    input logic      wr_busy,
    input logic      rd_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt;

    for (genvar m = 0; m < NUM_MST; m++) begin : g_mst
        a_b_hold: assert property (@(posedge seq) disable iff (!rst_n)
            mst_rsp[m].b_valid && !mst_req[m].b_ready
            |=> mst_rsp[m].b_valid && $stable(mst_rsp[m].b_resp))
            else begin
                $error("master B valid dropped before ready");
                fail_cnt++;
            end
        a_r_hold: assert property (@(posedge seq) disable iff (!rst_n)
            mst_rsp[m].r_valid && !mst_req[m].r_ready
            |=> mst_rsp[m].r_valid && $stable(mst_rsp[m].r_data))
            else begin
                $error("master R valid dropped before ready");
                fail_cnt++;
            end
    end

    for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
        a_aw_hold: assert property (@(posedge seq) disable iff (!rst_n)
            slv_req[s].aw_valid && !slv_rsp[s].aw_ready
            |=> slv_req[s].aw_valid && $stable(slv_req[s].aw_addr))
            else begin
                $error("slave AW valid dropped before ready");
                fail_cnt++;
            end
        a_w_hold: assert property (@(posedge seq) disable iff (!rst_n)
            slv_req[s].w_valid && !slv_rsp[s].w_ready
            |=> slv_req[s].w_valid && $stable(slv_req[s].w_data))
            else begin
                $error("slave W valid dropped before ready");
                fail_cnt++;
            end
        a_ar_hold: assert property (@(posedge seq) disable iff (!rst_n)
            slv_req[s].ar_valid && !slv_rsp[s].ar_ready
            |=> slv_req[s].ar_valid && $stable(slv_req[s].ar_addr))
            else begin
                $error("slave AR valid dropped before ready");
                fail_cnt++;
            end
        a_quiet: assert property (@(posedge seq) disable iff (!rst_n)
            paused |-> !(slv_req[s].aw_valid || slv_req[s].w_valid || slv_req[s].ar_valid))
            else begin
                $error("slave valid seen while paused");
                fail_cnt++;
            end
    end

    a_paused_idle: assert property (@(posedge seq) disable iff (!rst_n)
        $rose(paused) |-> $past(!wr_busy && !rd_busy))
        else begin
            $error("paused rose while a path was busy");
            fail_cnt++;
        end

endmodule

bind lsdom_fabric lsdom_fabric_assert #(
    .NUM_MST (NUM_MST)
) u_assert (
    .seq     (seq),
    .rst_n   (rst_n),
    .mst_req (mst_req),
    .mst_rsp (mst_rsp),
    .slv_req (slv_req),
    .slv_rsp (slv_rsp),
    .paused  (paused),
    .wr_busy (wr_busy),
    .rd_busy (rd_busy)
);

`default_nettype wire

//--- lsdom_fabric_tb.sv
`default_nettype none

module lsdom_fabric_tb
    import axil_pkg::*;
    import fabric_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_MST = 2;
    localparam int MAX_CYCLES = 3000;

    logic      seq;
    logic      rst_n;
    logic      pause;
    logic      paused;
    axil_req_t mst_req [NUM_MST];
    axil_rsp_t mst_rsp [NUM_MST];
    axil_req_t slv_req [NUM_SLV];
    axil_rsp_t slv_rsp [NUM_SLV];

    integer seed = 24739;
    int     cycles;
    int     checks;
    int     errors;
    int     valid_cnt;
    int     pause_viol;
    int     wdly [NUM_SLV];
    int     rdly [NUM_SLV];
    addr_t  last_off [NUM_SLV];
    strb_t  last_strb [NUM_SLV];
    int     grant_log [$];
    data_t  slave_mem [longint];
    data_t  shadow [longint];

    lsdom_fabric #(
        .NUM_MST (NUM_MST)
    ) dut0 (
        .seq     (seq),
        .rst_n   (rst_n),
        .mst_req (mst_req),
        .mst_rsp (mst_rsp),
        .slv_req (slv_req),
        .slv_rsp (slv_rsp),
        .pause   (pause),
        .paused  (paused)
    );

    initial begin
        seq = 1'b0;
        forever #2 seq = ~seq;
    end

    always @(posedge seq) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic longint mem_key(input int s, input addr_t off);
        return (longint'(s) << 32) | longint'(off >> 2);
    endfunction

    function automatic data_t merge(input data_t old, input data_t nw, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = nw[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Expected routing, straight from the address map.
    task automatic region_of(input addr_t addr, output int s, output addr_t off, output bit hit);
        hit = 1'b1;
        s   = 0;
        off = addr;
        if (addr >= 32'h0008_0000) begin
            s   = 2;
            off = addr - 32'h0008_0000;
        end else if (addr >= 32'h0000_8000 && addr <= 32'h0000_83FF) begin
            s   = 1;
            off = addr - 32'h0000_8000;
        end else if (addr > 32'h0000_7FFF) begin
            hit = 1'b0;
        end
    endtask

    // Slave models decide on stable values at the falling edge.
    always @(negedge seq) begin
        axil_rsp_t nxt [NUM_SLV];
        longint    key;
        for (int s = 0; s < NUM_SLV; s++) begin
            nxt[s] = slv_rsp[s];
            nxt[s].aw_ready = 1'b0;
            nxt[s].w_ready  = 1'b0;
            nxt[s].ar_ready = 1'b0;
            if (slv_rsp[s].b_valid && slv_req[s].b_ready) begin
                nxt[s].b_valid = 1'b0;
            end
            if (slv_rsp[s].r_valid && slv_req[s].r_ready) begin
                nxt[s].r_valid = 1'b0;
            end
            if (slv_req[s].aw_valid && slv_rsp[s].aw_ready) begin
                key = mem_key(s, slv_req[s].aw_addr);
                slave_mem[key] = merge(slave_mem.exists(key) ? slave_mem[key] : '0,
                                       slv_req[s].w_data, slv_req[s].w_strb);
                last_off[s]    = slv_req[s].aw_addr;
                last_strb[s]   = slv_req[s].w_strb;
                nxt[s].b_valid = 1'b1;
                nxt[s].b_resp  = RESP_OKAY;
            end else if (slv_req[s].aw_valid && slv_req[s].w_valid && !slv_rsp[s].b_valid) begin
                if (wdly[s] == 0) begin
                    nxt[s].aw_ready = 1'b1;
                    nxt[s].w_ready  = 1'b1;
                    wdly[s] = int'($unsigned($random(seed)) % 4);
                end else begin
                    wdly[s]--;
                end
            end
            if (slv_req[s].ar_valid && slv_rsp[s].ar_ready) begin
                key = mem_key(s, slv_req[s].ar_addr);
                nxt[s].r_valid = 1'b1;
                nxt[s].r_data  = slave_mem.exists(key) ? slave_mem[key] : '0;
                nxt[s].r_resp  = RESP_OKAY;
            end else if (slv_req[s].ar_valid && !slv_rsp[s].r_valid) begin
                if (rdly[s] == 0) begin
                    nxt[s].ar_ready = 1'b1;
                    rdly[s] = int'($unsigned($random(seed)) % 4);
                end else begin
                    rdly[s]--;
                end
            end
        end
        @(posedge seq);
        #1;
        for (int s = 0; s < NUM_SLV; s++) begin
            slv_rsp[s] = nxt[s];
        end
    end

    always @(negedge seq) begin
        for (int m = 0; m < NUM_MST; m++) begin
            if (mst_rsp[m].aw_ready) begin
                grant_log.push_back(m);
            end
        end
        for (int s = 0; s < NUM_SLV; s++) begin
            if (slv_req[s].aw_valid || slv_req[s].w_valid || slv_req[s].ar_valid) begin
                valid_cnt++;
                if (paused) begin
                    pause_viol++;
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic do_write(input int m, input addr_t addr, input data_t data,
                            input strb_t strb, input string name, input bit chk_slv);
        int     s;
        addr_t  off;
        bit     hit;
        resp_t  resp;
        int     n0;
        longint key;
        region_of(addr, s, off, hit);
        n0 = valid_cnt;
        mst_req[m].aw_valid = 1'b1;
        mst_req[m].aw_addr  = addr;
        mst_req[m].w_valid  = 1'b1;
        mst_req[m].w_data   = data;
        mst_req[m].w_strb   = strb;
        do @(negedge seq); while (!mst_rsp[m].aw_ready);
        check_val({name, " w_ready"}, 1, 32'(mst_rsp[m].w_ready));
        @(posedge seq);
        #1;
        mst_req[m].aw_valid = 1'b0;
        mst_req[m].w_valid  = 1'b0;
        do @(negedge seq); while (!mst_rsp[m].b_valid);
        resp = mst_rsp[m].b_resp;
        // B waits one cycle with b_ready low before it is taken.
        @(posedge seq);
        #1;
        mst_req[m].b_ready = 1'b1;
        @(posedge seq);
        #1;
        mst_req[m].b_ready = 1'b0;
        check_val({name, " b_resp"}, 32'(hit ? RESP_OKAY : RESP_DECERR), 32'(resp));
        if (hit) begin
            key = mem_key(s, off);
            shadow[key] = merge(shadow.exists(key) ? shadow[key] : '0, data, strb);
            if (chk_slv) begin
                check_val({name, " slave offset"}, off, last_off[s]);
                check_val({name, " slave strobe"}, 32'(strb), 32'(last_strb[s]));
            end
        end else begin
            check_val({name, " slave valids"}, n0, valid_cnt);
        end
    endtask

    task automatic do_read(input int m, input addr_t addr, input string name);
        int     s;
        addr_t  off;
        bit     hit;
        data_t  exp;
        int     n0;
        longint key;
        region_of(addr, s, off, hit);
        key = mem_key(s, off);
        exp = (hit && shadow.exists(key)) ? shadow[key] : '0;
        n0  = valid_cnt;
        mst_req[m].ar_valid = 1'b1;
        mst_req[m].ar_addr  = addr;
        do @(negedge seq); while (!mst_rsp[m].ar_ready);
        @(posedge seq);
        #1;
        mst_req[m].ar_valid = 1'b0;
        do @(negedge seq); while (!mst_rsp[m].r_valid);
        check_val({name, " r_resp"}, 32'(hit ? RESP_OKAY : RESP_DECERR), 32'(mst_rsp[m].r_resp));
        check_val({name, " r_data"}, exp, mst_rsp[m].r_data);
        if (!hit) begin
            check_val({name, " slave valids"}, n0, valid_cnt);
        end
        @(posedge seq);
        #1;
        mst_req[m].r_ready = 1'b1;
        @(posedge seq);
        #1;
        mst_req[m].r_ready = 1'b0;
    endtask

    initial begin
        addr_t edges [6];
        edges = '{32'h0, 32'h7FFC, 32'h8000, 32'h83FC, 32'h0008_0000, 32'hFFFF_FFFC};
        rst_n = 1'b0;
        pause = 1'b0;
        for (int m = 0; m < NUM_MST; m++) begin
            mst_req[m] = '0;
        end
        for (int s = 0; s < NUM_SLV; s++) begin
            slv_rsp[s] = '0;
        end
        repeat (8) @(posedge seq);
        #1;
        rst_n = 1'b1;

        for (int m = 0; m < NUM_MST; m++) begin
            foreach (edges[i]) begin
                do_write(m, edges[i], $random(seed), 4'hF, "edge write", 1'b1);
                do_read(m, edges[i], "edge read");
            end
        end

        do_write(0, 32'h100, 32'h1122_3344, 4'hF, "strobe base", 1'b1);
        do_write(1, 32'h100, 32'hAABB_CCDD, 4'b0101, "strobe partial", 1'b1);
        do_read(0, 32'h100, "strobe merge");

        do_write(0, 32'h8400, 32'hDEAD_BEEF, 4'hF, "hole write", 1'b0);
        do_read(1, 32'h8400, "hole read");
        do_write(1, 32'h7_FFFC, 32'hDEAD_BEEF, 4'hF, "hole write", 1'b0);
        do_read(0, 32'h7_FFFC, "hole read");

        // Back-to-back writes from both masters to lpmem.
        grant_log.delete();
        fork
            for (int i = 0; i < 4; i++) begin
                do_write(0, 32'h200 + 8 * i, $random(seed), 4'hF, "rr m0", 1'b0);
            end
            for (int i = 0; i < 4; i++) begin
                do_write(1, 32'h204 + 8 * i, $random(seed), 4'hF, "rr m1", 1'b0);
            end
        join
        check_val("rr grants", 8, grant_log.size());
        for (int i = 1; i < grant_log.size(); i++) begin
            checks++;
            assert (grant_log[i] != grant_log[i-1]) else begin
                errors++;
                $display("Round robin broken: master %0d granted twice in a row", grant_log[i]);
            end
        end

        do_write(1, 32'h8010, 32'h5A5A_0001, 4'hF, "overlap init", 1'b1);
        fork
            begin
                do_write(0, 32'h300, 32'h0BAD_F00D, 4'hF, "overlap write", 1'b1);
                do_read(0, 32'h300, "overlap read m0");
            end
            begin
                do_read(1, 32'h8010, "overlap read m1");
                do_write(1, 32'h8014, 32'h7777_1234, 4'hF, "overlap write m1", 1'b1);
            end
        join

        pause_viol = 0;
        fork
            begin
                do_write(0, 32'h0010_0000, 32'hCAFE_0001, 4'hF, "pause write", 1'b1);
                do_write(0, 32'h0010_0004, 32'hCAFE_0002, 4'hF, "pause pending", 1'b1);
            end
            do_read(1, 32'h300, "pause read");
            begin
                repeat (3) @(posedge seq);
                #1;
                pause = 1'b1;
                do @(negedge seq); while (!paused);
                repeat (10) @(posedge seq);
                #1;
                check_val("paused held", 1, 32'(paused));
                pause = 1'b0;
            end
        join
        check_val("valids while paused", 0, pause_viol);
        do_read(1, 32'h0010_0004, "after pause read");

        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut0.u_assert.fail_cnt);
        if (errors == 0 && dut0.u_assert.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
axil_pkg.sv
fabric_pkg.sv
addr_decoder.sv
rr_arbiter.sv
axil_write_switch.sv
axil_read_switch.sv
fabric_pause_ctrl.sv
lsdom_fabric.sv
lsdom_fabric_assert.sv
lsdom_fabric_tb.sv

//--- Makefile
TOP := lsdom_fabric_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
